// File: source/sort_macros.svh
`ifndef SORT_MACROS_SVH
`define SORT_MACROS_SVH

// Record i of a flattened array, record 0 in the low bits
`define index_flat(arr, i) arr[(i)*pair_width +: pair_width]

// Copies n records from one array to another
`define pass_through(src, dst, n) \
    for (int pass_i = 0; pass_i < (n); pass_i++) \
        dst[pass_i] = src[pass_i];

`endif

// File: source/sort_types_pkg.sv
`default_nettype none

package sort_types_pkg;

    localparam int key_width        = 16;
    localparam int value_width      = 16;
    localparam int pair_width       = key_width + value_width;
    localparam int num_pairs        = 8;
    localparam int pairs_flat_width = num_pairs * pair_width;

    // Key sits in the upper half so whole-word compares order by key first
    typedef struct packed {
        logic [key_width-1:0]   key;
        logic [value_width-1:0] value;
    } pair_t;

    typedef enum logic [1:0] {
        op_sort_asc     = 2'd0,
        op_sort_desc    = 2'd1,
        op_accum_middle = 2'd2,
        op_clear_sum    = 2'd3
    } sort_op_t;

    // Returns {first, second}, smaller first when ascending
    function automatic logic [2*pair_width-1:0] cmp_swp(input pair_t a, input pair_t b,
                                                        input logic asc);
        logic [pair_width-1:0] a_word;
        logic [pair_width-1:0] b_word;
        logic                  a_first;
        a_word  = a;
        b_word  = b;
        a_first = asc ? (a_word <= b_word) : (a_word >= b_word);
        return a_first ? {a, b} : {b, a};
    endfunction

endpackage

`default_nettype wire

// File: source/sort_pipe_pkg.sv
`default_nettype none

package sort_pipe_pkg;

    // Register stages in the sorting network
    localparam int sort_stages = 6;

    // Enough opcode tags for every item the sorter can hold
    localparam int tag_depth      = 8;
    localparam int tag_addr_width = $clog2(tag_depth);

    localparam int sum_width = 32;

endpackage

`default_nettype wire

// File: source/sort_command_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sort_command_decode import sort_types_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        cmd_valid,
    input  sort_op_t                    cmd_op,
    input  logic [pairs_flat_width-1:0] cmd_pairs_flat,
    input  logic                        sorter_saturated,
    input  logic                        stall,
    output logic                        cmd_ready,
    output logic                        valid_in,
    output logic                        asc_in,
    output logic [pairs_flat_width-1:0] pairs_in_flat,
    output logic                        tag_push,
    output sort_op_t                    tag_op
);
    logic                        held_valid;
    sort_op_t                    held_op;
    logic [pairs_flat_width-1:0] held_pairs;
    logic                        sorter_takes;

    assign sorter_takes = !(sorter_saturated && stall);  // First stage only holds when all are full
    assign cmd_ready    = !held_valid || sorter_takes;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (cmd_ready) begin
            held_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_valid && cmd_ready) begin
            held_op    <= cmd_op;
            held_pairs <= cmd_pairs_flat;
        end
    end

    assign valid_in      = held_valid;
    assign asc_in        = (held_op != op_sort_desc);  // Accumulate and clear also sort ascending
    assign pairs_in_flat = held_pairs;
    assign tag_push      = held_valid && sorter_takes;
    assign tag_op        = held_op;

endmodule

`default_nettype wire

// File: source/sorter_8.sv
`timescale 1ns/1ns
`include "sort_macros.svh"
`default_nettype none

module sorter_8 import sort_types_pkg::*, sort_pipe_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        valid_in,
    input  logic                        asc_in,
    input  logic                        stall_in,
    input  logic [pairs_flat_width-1:0] pairs_in_flat,
    output logic                        valid_out,
    output logic                        saturated_out,
    output logic [pairs_flat_width-1:0] pairs_out_flat
);
    pair_t                  pairs_in_unpack [num_pairs];
    pair_t                  stage_next [1:sort_stages][num_pairs];
    pair_t                  stage_data [1:sort_stages][num_pairs];
    logic [sort_stages-1:1] stage_dir;
    logic [sort_stages:1]   stage_valid;
    logic [sort_stages:1]   stage_stall;

    always_comb begin
        for (int i = 0; i < num_pairs; i++) begin
            pairs_in_unpack[i] = `index_flat(pairs_in_flat, i);
        end
    end

    // A stage holds only while it is occupied and everything after it holds
    always_comb begin
        logic hold;
        hold = stall_in;
        for (int k = sort_stages; k >= 1; k--) begin
            hold           = hold && stage_valid[k];
            stage_stall[k] = hold;
        end
    end

    // Odd-even merge network, 19 comparators over six layers
    always_comb begin
        `pass_through(pairs_in_unpack, stage_next[1], num_pairs)
        for (int k = 2; k <= sort_stages; k++) begin
            `pass_through(stage_data[k-1], stage_next[k], num_pairs)
        end

        for (int i = 0; i < num_pairs; i += 4) begin
            {stage_next[1][i], stage_next[1][i+2]} =
                cmp_swp(pairs_in_unpack[i], pairs_in_unpack[i+2], asc_in);
            {stage_next[1][i+1], stage_next[1][i+3]} =
                cmp_swp(pairs_in_unpack[i+1], pairs_in_unpack[i+3], asc_in);
        end

        for (int i = 0; i < 4; i++) begin
            {stage_next[2][i], stage_next[2][i+4]} =
                cmp_swp(stage_data[1][i], stage_data[1][i+4], stage_dir[1]);
        end

        for (int i = 0; i < num_pairs; i += 2) begin
            {stage_next[3][i], stage_next[3][i+1]} =
                cmp_swp(stage_data[2][i], stage_data[2][i+1], stage_dir[2]);
        end

        for (int i = 2; i < 4; i++) begin
            {stage_next[4][i], stage_next[4][i+2]} =
                cmp_swp(stage_data[3][i], stage_data[3][i+2], stage_dir[3]);
        end

        for (int i = 1; i < 4; i += 2) begin
            {stage_next[5][i], stage_next[5][i+3]} =
                cmp_swp(stage_data[4][i], stage_data[4][i+3], stage_dir[4]);
        end

        for (int i = 1; i < 7; i += 2) begin
            {stage_next[6][i], stage_next[6][i+1]} =
                cmp_swp(stage_data[5][i], stage_data[5][i+1], stage_dir[5]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            if (!stage_stall[1]) begin
                stage_valid[1] <= valid_in;
            end
            for (int k = 2; k <= sort_stages; k++) begin
                if (!stage_stall[k]) begin
                    stage_valid[k] <= stage_valid[k-1];  // Bubbles get overwritten while later stages hold
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 1; k <= sort_stages; k++) begin
            if (!stage_stall[k]) begin
                stage_data[k] <= stage_next[k];
            end
        end
        if (!stage_stall[1]) begin
            stage_dir[1] <= asc_in;
        end
        for (int k = 2; k < sort_stages; k++) begin
            if (!stage_stall[k]) begin
                stage_dir[k] <= stage_dir[k-1];  // The last layer needs no direction after it
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_pairs; i++) begin
            `index_flat(pairs_out_flat, i) = stage_data[sort_stages][i];
        end
    end

    assign saturated_out = &stage_valid;
    assign valid_out     = stage_valid[sort_stages];

endmodule

`default_nettype wire

// File: source/sort_result_unit.sv
`timescale 1ns/1ns
`include "sort_macros.svh"
`default_nettype none

module sort_result_unit import sort_types_pkg::*, sort_pipe_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        tag_push,
    input  sort_op_t                    tag_op,
    input  logic                        sorted_valid,
    input  logic [pairs_flat_width-1:0] sorted_pairs_flat,
    input  logic                        res_ready,
    output logic                        stall,
    output logic                        res_valid,
    output sort_op_t                    res_op,
    output logic [pairs_flat_width-1:0] res_pairs_flat,
    output logic [sum_width-1:0]        res_sum
);
    sort_op_t                  tag_mem [tag_depth];
    logic [tag_addr_width-1:0] wr_ptr;
    logic [tag_addr_width-1:0] rd_ptr;
    logic [sum_width-1:0]      sum_acc;
    pair_t                     middle;
    logic                      res_fire;

    assign stall          = !res_ready;
    assign res_valid      = sorted_valid;
    assign res_pairs_flat = sorted_pairs_flat;
    assign res_fire       = res_valid && res_ready;

    // Sorter keeps order, so tags come back out in push order
    assign res_op = tag_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (tag_push) begin
            tag_mem[wr_ptr] <= tag_op;
        end
    end

    assign middle = `index_flat(sorted_pairs_flat, num_pairs / 2);

    // Sum as it stands once this result is taken
    always_comb begin
        case (res_op)
            op_accum_middle: res_sum = sum_acc + sum_width'(middle.key);
            op_clear_sum:    res_sum = '0;
            default:         res_sum = sum_acc;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            sum_acc <= '0;
        end else begin
            if (tag_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (res_fire) begin
                rd_ptr  <= rd_ptr + 1'b1;
                sum_acc <= res_sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sort_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module sort_accel_top import sort_types_pkg::*, sort_pipe_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        cmd_valid,
    input  sort_op_t                    cmd_op,
    input  logic [pairs_flat_width-1:0] cmd_pairs_flat,
    input  logic                        res_ready,
    output logic                        cmd_ready,
    output logic                        res_valid,
    output sort_op_t                    res_op,
    output logic [pairs_flat_width-1:0] res_pairs_flat,
    output logic [sum_width-1:0]        res_sum
);
    logic                        valid_in;
    logic                        asc_in;
    logic [pairs_flat_width-1:0] pairs_in_flat;
    logic                        saturated;
    logic                        stall;
    logic                        sorted_valid;
    logic [pairs_flat_width-1:0] sorted_pairs_flat;
    logic                        tag_push;
    sort_op_t                    tag_op;

    sort_command_decode u_sort_command_decode (
        .clock            (clock),
        .reset            (reset),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_pairs_flat   (cmd_pairs_flat),
        .sorter_saturated (saturated),
        .stall            (stall),
        .cmd_ready        (cmd_ready),
        .valid_in         (valid_in),
        .asc_in           (asc_in),
        .pairs_in_flat    (pairs_in_flat),
        .tag_push         (tag_push),
        .tag_op           (tag_op)
    );

    sorter_8 u_sorter_8 (
        .clock          (clock),
        .reset          (reset),
        .valid_in       (valid_in),
        .asc_in         (asc_in),
        .stall_in       (stall),
        .pairs_in_flat  (pairs_in_flat),
        .valid_out      (sorted_valid),
        .saturated_out  (saturated),
        .pairs_out_flat (sorted_pairs_flat)
    );

    sort_result_unit u_sort_result_unit (
        .clock             (clock),
        .reset             (reset),
        .tag_push          (tag_push),
        .tag_op            (tag_op),
        .sorted_valid      (sorted_valid),
        .sorted_pairs_flat (sorted_pairs_flat),
        .res_ready         (res_ready),
        .stall             (stall),
        .res_valid         (res_valid),
        .res_op            (res_op),
        .res_pairs_flat    (res_pairs_flat),
        .res_sum           (res_sum)
    );

endmodule

`default_nettype wire

// File: bench/sort_accel_tests.svh
`ifndef SORT_ACCEL_TESTS_SVH
`define SORT_ACCEL_TESTS_SVH

task automatic check_reset_state();
    test_name = "reset_state";
    #10;
    if (res_valid !== 1'b0 || cmd_ready !== 1'b1 || res_sum !== '0) begin
        error_count++;
        $display("Error %s: expected valid 0 ready 1 sum 0 actual valid %b ready %b sum %0h",
                 test_name, res_valid, cmd_ready, res_sum);
    end
endtask

task automatic ascending_sort();
    test_name = "sort_asc";
    for (int n = 0; n < 20; n++) begin
        send_cmd(op_sort_asc, random_pairs());
    end
    wait_drain();
endtask

task automatic descending_sort();
    logic [pairs_flat_width-1:0] pairs;
    test_name = "sort_desc";
    for (int n = 0; n < 20; n++) begin
        pairs = random_pairs();
        if (n % 2 == 1) begin
            pairs[3*pair_width +: pair_width] = pairs[0 +: pair_width];  // Whole record repeated
            pairs[6*pair_width +: pair_width] = pairs[0 +: pair_width];
            pairs[7*pair_width + value_width +: key_width] = pairs[value_width +: key_width];
        end
        send_cmd(op_sort_desc, pairs);
    end
    wait_drain();
endtask

task automatic middle_key_sum();
    test_name = "middle_sum";
    send_cmd(op_clear_sum, random_pairs());
    for (int n = 0; n < 12; n++) begin
        if (n == 6) begin
            send_cmd(op_clear_sum, random_pairs());
        end else begin
            send_cmd(op_accum_middle, random_pairs());
        end
    end
    wait_drain();
endtask

task automatic back_pressure();
    logic [pairs_flat_width-1:0] pairs;
    logic                        accepted;
    int                          taken;
    test_name    = "back_pressure";
    ready_random = 1'b1;
    for (int n = 0; n < 24; n++) begin
        send_cmd(sort_op_t'(n % 4), random_pairs());
    end
    wait_drain();
    ready_random = 1'b0;
    ready_level  = 1'b0;
    taken        = 0;
    accepted     = 1'b1;
    while (accepted && taken <= tag_depth) begin
        pairs = random_pairs();
        try_cmd(op_sort_asc, pairs, accepted);
        if (accepted) begin
            taken++;
        end
    end
    if (accepted) begin
        error_count++;
        $display("cmd_ready never fell while res_ready was held low");
    end else if (taken != 1 + sort_stages) begin  // Decode register plus every sorter stage
        error_count++;
        $display("Error %s: expected %0d commands accepted actual %0d", test_name,
                 1 + sort_stages, taken);
    end
    ready_level = 1'b1;
    send_cmd(op_sort_asc, pairs);
    wait_drain();
endtask

task automatic measure_latency();
    int start;
    test_name   = "latency";
    ready_level = 1'b1;
    send_cmd(op_sort_asc, random_pairs());
    start = cycle_count + 1;  // Counter value once the transfer edge has passed
    wait_drain();
    // The transfer edge loads the decode register and each sorter stage adds one edge
    if (rise_cycle != start + sort_stages) begin
        error_count++;
        $display("Error %s: expected res_valid at cycle %0d actual %0d", test_name,
                 start + sort_stages, rise_cycle);
    end
endtask

`endif

// File: bench/sort_accel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sort_accel_tb import sort_types_pkg::*, sort_pipe_pkg::*; ();

    localparam int max_cycles = 4000;  // Far above the two hundred or so cycles that all tests take

    logic                                 clock;
    logic                                 reset;
    logic                                 cmd_valid;
    sort_op_t                             cmd_op;
    logic [pairs_flat_width-1:0]          cmd_pairs_flat;
    logic                                 res_ready;
    logic                                 cmd_ready;
    logic                                 res_valid;
    sort_op_t                             res_op;
    logic [pairs_flat_width-1:0]          res_pairs_flat;
    logic [sum_width-1:0]                 res_sum;

    logic [pairs_flat_width-1:0]          exp_pairs [$];
    sort_op_t                             exp_op [$];
    logic [sum_width-1:0]                 exp_sum [$];
    logic [sum_width-1:0]                 model_sum;
    logic [31:0]                          data_seed;
    logic [31:0]                          ready_seed;
    logic                                 ready_random;
    logic                                 ready_level;
    logic                                 valid_prev;
    logic                                 held_prev;
    logic [pairs_flat_width+sum_width+2:0] held_word;
    int                                   error_count;
    int                                   cycle_count;
    int                                   rise_cycle;
    string                                test_name;

    sort_accel_top u_sort_accel_top (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state;
    endfunction

    function automatic logic [pairs_flat_width-1:0] random_pairs();
        logic [pairs_flat_width-1:0] flat;
        for (int i = 0; i < num_pairs; i++) begin
            flat[i*pair_width +: pair_width] = lcg_next(data_seed);
        end
        return flat;
    endfunction

    // Bubble sort on whole 32-bit records with index 0 first in the result
    function automatic logic [pairs_flat_width-1:0] model_sort(
        input logic [pairs_flat_width-1:0] flat, input logic asc);
        logic [pair_width-1:0] a;
        logic [pair_width-1:0] b;
        for (int i = 0; i < num_pairs - 1; i++) begin
            for (int j = 0; j < num_pairs - 1 - i; j++) begin
                a = flat[j*pair_width +: pair_width];
                b = flat[(j+1)*pair_width +: pair_width];
                if (asc ? (a > b) : (a < b)) begin
                    flat[j*pair_width +: pair_width]     = b;
                    flat[(j+1)*pair_width +: pair_width] = a;
                end
            end
        end
        return flat;
    endfunction

    task automatic expect_result(input sort_op_t op, input logic [pairs_flat_width-1:0] pairs);
        logic [pairs_flat_width-1:0] sorted;
        sorted = model_sort(pairs, op != op_sort_desc);
        if (op == op_accum_middle) begin
            model_sum = model_sum
                      + sum_width'(sorted[(num_pairs/2)*pair_width + value_width +: key_width]);
        end else if (op == op_clear_sum) begin
            model_sum = '0;
        end
        exp_pairs.push_back(sorted);
        exp_op.push_back(op);
        exp_sum.push_back(model_sum);
    endtask

    task automatic compare_value(input string what, input logic [pairs_flat_width-1:0] expected,
                                 input logic [pairs_flat_width-1:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic score_result();
        if (exp_op.size() == 0) begin
            error_count++;
            $display("A result came out with no command outstanding during %s", test_name);
        end else begin
            compare_value("pairs", exp_pairs.pop_front(), res_pairs_flat);
            compare_value("op", pairs_flat_width'(exp_op.pop_front()), pairs_flat_width'(res_op));
            compare_value("sum", pairs_flat_width'(exp_sum.pop_front()),
                          pairs_flat_width'(res_sum));
        end
    endtask

    // Presents a command for one cycle and reports whether the next rising edge takes it
    task automatic try_cmd(input sort_op_t op, input logic [pairs_flat_width-1:0] pairs,
                           output logic accepted);
        @(negedge clock);
        cmd_valid      = 1'b1;
        cmd_op         = op;
        cmd_pairs_flat = pairs;
        #10;
        accepted = cmd_ready;
        if (accepted) begin
            expect_result(op, pairs);
        end
    endtask

    task automatic send_cmd(input sort_op_t op, input logic [pairs_flat_width-1:0] pairs);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            try_cmd(op, pairs, accepted);
        end
    endtask

    task automatic wait_drain();
        @(negedge clock);
        cmd_valid = 1'b0;
        while (exp_op.size() != 0) begin
            @(negedge clock);
            #20;
        end
    endtask

    always @(negedge clock) begin
        logic [31:0] r;
        r = lcg_next(ready_seed);
        res_ready = ready_random ? r[20] : ready_level;
    end

    // The result monitor samples between the falling edge and the next rising edge
    always begin
        @(negedge clock);
        #10;
        if (!reset) begin
            if (held_prev && {res_valid, res_op, res_sum, res_pairs_flat} !== held_word) begin
                error_count++;
                $display("Error %s held result: expected %0h actual %0h", test_name, held_word,
                         {res_valid, res_op, res_sum, res_pairs_flat});
            end
            if (res_valid && !valid_prev) begin
                rise_cycle = cycle_count;
            end
            if (res_valid && res_ready) begin
                score_result();
            end
            held_prev  = res_valid && !res_ready;
            held_word  = {res_valid, res_op, res_sum, res_pairs_flat};
            valid_prev = res_valid;
        end
    end

    `include "sort_accel_tests.svh"

    initial begin
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = op_sort_asc;
        cmd_pairs_flat = '0;
        res_ready      = 1'b1;
        ready_random   = 1'b0;
        ready_level    = 1'b1;
        data_seed      = 32'd64;
        ready_seed     = 32'd64;
        model_sum      = '0;
        valid_prev     = 1'b0;
        held_prev      = 1'b0;
        held_word      = '0;
        error_count    = 0;
        cycle_count    = 0;
        rise_cycle     = 0;
        test_name      = "reset";
        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_reset_state();
        ascending_sort();
        descending_sort();
        middle_key_sum();
        back_pressure();
        measure_latency();
        wait_drain();
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
+incdir+bench
source/sort_types_pkg.sv
source/sort_pipe_pkg.sv
source/sort_command_decode.sv
source/sorter_8.sv
source/sort_result_unit.sv
source/sort_accel_top.sv
bench/sort_accel_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sort_accel_tb
RTL_TOP   ?= sort_accel_top
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP) $(VFLAGS)

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP) $(VFLAGS)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
